//--- design/lcd_hex_pkg.sv
`default_nettype none

package lcd_hex_pkg;

    localparam int ram_depth  = 256;
    localparam int addr_bits  = 8;
    localparam int disp_bytes = 8; // shadow bytes behind the display word

    // panel geometry
    localparam int lcd_width  = 32;
    localparam int lcd_height = 16;
    localparam int color_bits = 16;
    localparam int x_bits     = $clog2(lcd_width);
    localparam int y_bits     = $clog2(lcd_height);
    localparam int glyph_w    = 4;
    localparam int glyph_h    = 8;
    localparam int gap_cycles = 4; // csn high time between frames

    localparam logic [color_bits-1:0] fg_color = 16'hffff;
    localparam logic [color_bits-1:0] bg_color = 16'h0000;

    typedef enum logic [7:0] {
        op_write = 8'h02,
        op_read  = 8'h03
    } spi_op_t;

    typedef enum logic [2:0] {
        idle,
        init_byte,
        frame_cmd,
        pixels,
        gap
    } lcd_state_t;

    localparam int init_len = 3;
    localparam logic [7:0] init_bytes [init_len] = '{8'h11, 8'h3a, 8'h55};
    localparam logic [7:0] ramwr_cmd = 8'h2c; // memory write, starts each frame

    // 4x8 hex digits, bit 3 is the leftmost pixel, last row blank
    localparam logic [3:0] font [16][8] = '{
        '{4'h6, 4'h9, 4'h9, 4'h9, 4'h9, 4'h9, 4'h6, 4'h0}, // 0
        '{4'h2, 4'h6, 4'h2, 4'h2, 4'h2, 4'h2, 4'h7, 4'h0}, // 1
        '{4'h6, 4'h9, 4'h1, 4'h2, 4'h4, 4'h8, 4'hf, 4'h0}, // 2
        '{4'he, 4'h1, 4'h1, 4'h6, 4'h1, 4'h1, 4'he, 4'h0}, // 3
        '{4'h9, 4'h9, 4'h9, 4'hf, 4'h1, 4'h1, 4'h1, 4'h0}, // 4
        '{4'hf, 4'h8, 4'h8, 4'he, 4'h1, 4'h1, 4'he, 4'h0}, // 5
        '{4'h6, 4'h8, 4'h8, 4'he, 4'h9, 4'h9, 4'h6, 4'h0}, // 6
        '{4'hf, 4'h1, 4'h1, 4'h2, 4'h4, 4'h4, 4'h4, 4'h0}, // 7
        '{4'h6, 4'h9, 4'h9, 4'h6, 4'h9, 4'h9, 4'h6, 4'h0}, // 8
        '{4'h6, 4'h9, 4'h9, 4'h7, 4'h1, 4'h1, 4'h6, 4'h0}, // 9
        '{4'h6, 4'h9, 4'h9, 4'hf, 4'h9, 4'h9, 4'h9, 4'h0}, // a
        '{4'he, 4'h9, 4'h9, 4'he, 4'h9, 4'h9, 4'he, 4'h0}, // b
        '{4'h6, 4'h9, 4'h8, 4'h8, 4'h8, 4'h9, 4'h6, 4'h0}, // c
        '{4'he, 4'h9, 4'h9, 4'h9, 4'h9, 4'h9, 4'he, 4'h0}, // d
        '{4'hf, 4'h8, 4'h8, 4'he, 4'h8, 4'h8, 4'hf, 4'h0}, // e
        '{4'hf, 4'h8, 4'h8, 4'he, 4'h8, 4'h8, 4'h8, 4'h0}  // f
    };

endpackage

`default_nettype wire

//--- design/mem_if.sv
`default_nettype none

// RAM access path between the SPI slave and the byte RAM
interface mem_if;

    logic                            wr;    // one-cycle write strobe
    logic [lcd_hex_pkg::addr_bits-1:0] addr;
    logic [7:0]                      wdata;
    logic [7:0]                      rdata; // valid one cycle after addr

    modport slave (
        output wr, addr, wdata,
        input  rdata
    );

    modport ram (
        input  wr, addr, wdata,
        output rdata
    );

endinterface

`default_nettype wire

//--- design/spi_rw_slave.sv
`default_nettype none

module spi_rw_slave (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  csn,
    input  wire  sclk,
    input  wire  mosi,
    output logic miso,
    mem_if.slave mem
);

    typedef enum logic [1:0] {
        ph_opcode,
        ph_addr,
        ph_data,
        ph_skip // unknown opcode, ignore until csn rises
    } phase_t;

    logic [1:0] csn_sr;
    logic [2:0] sclk_sr; // two sync flops plus one for edge detect
    logic [1:0] mosi_sr;
    logic       csn_s;
    logic       sclk_rise;
    logic       sclk_fall;
    logic [6:0] rx_sr;
    logic [7:0] rx_byte;
    logic [2:0] bit_cnt;
    logic [7:0] tx_sr;
    logic       tx_pending;
    phase_t     phase;
    lcd_hex_pkg::spi_op_t op;

    assign csn_s     = csn_sr[1];
    assign sclk_rise = sclk_sr[1] & ~sclk_sr[2];
    assign sclk_fall = ~sclk_sr[1] & sclk_sr[2];
    assign rx_byte   = {rx_sr, mosi_sr[1]};
    assign miso      = tx_sr[7]; // tx_sr is cleared while deselected

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            csn_sr  <= 2'b11;
            sclk_sr <= 3'b000;
            mosi_sr <= 2'b00;
        end
        else
        begin
            csn_sr  <= {csn_sr[0], csn};
            sclk_sr <= {sclk_sr[1:0], sclk};
            mosi_sr <= {mosi_sr[0], mosi};
        end
    end

    // byte assembly and command decode
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            phase      <= ph_opcode;
            op         <= lcd_hex_pkg::op_write;
            bit_cnt    <= 3'd0;
            tx_sr      <= 8'h00;
            tx_pending <= 1'b0;
            mem.wr     <= 1'b0;
            mem.addr   <= '0;
        end
        else
        begin
            mem.wr <= 1'b0;
            if (mem.wr)
                mem.addr <= mem.addr + 1'b1; // step past the byte just written

            if (csn_s)
            begin
                // abort, wait for the next opcode
                phase      <= ph_opcode;
                bit_cnt    <= 3'd0;
                tx_sr      <= 8'h00;
                tx_pending <= 1'b0;
            end
            else
            begin
                if (sclk_rise)
                begin
                    rx_sr   <= rx_byte[6:0];
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == 3'd7)
                    begin
                        case (phase)
                            ph_opcode:
                                if (rx_byte == lcd_hex_pkg::op_write ||
                                    rx_byte == lcd_hex_pkg::op_read)
                                begin
                                    op    <= lcd_hex_pkg::spi_op_t'(rx_byte);
                                    phase <= ph_addr;
                                end
                                else
                                    phase <= ph_skip;
                            ph_addr:
                            begin
                                mem.addr   <= rx_byte;
                                phase      <= ph_data;
                                tx_pending <= (op == lcd_hex_pkg::op_read);
                            end
                            ph_data:
                                if (op == lcd_hex_pkg::op_write)
                                begin
                                    mem.wr    <= 1'b1;
                                    mem.wdata <= rx_byte;
                                end
                                else
                                begin
                                    mem.addr   <= mem.addr + 1'b1;
                                    tx_pending <= 1'b1; // fetch next byte
                                end
                            default: ;
                        endcase
                    end
                end

                // miso changes on the falling edge, mode 0
                if (sclk_fall)
                begin
                    if (tx_pending)
                    begin
                        tx_sr      <= mem.rdata;
                        tx_pending <= 1'b0;
                    end
                    else
                        tx_sr <= {tx_sr[6:0], 1'b0};
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/byte_ram.sv
`default_nettype none

module byte_ram (
    input  wire  clk,
    mem_if.ram   mem,
    output logic [lcd_hex_pkg::disp_bytes*8-1:0] disp_word
);

    localparam int shadow_bits = $clog2(lcd_hex_pkg::disp_bytes);

    logic [7:0] ram    [lcd_hex_pkg::ram_depth];
    logic [7:0] shadow [lcd_hex_pkg::disp_bytes]; // copy of bytes 0..7

    always_ff @(posedge clk)
    begin
        if (mem.wr)
        begin
            ram[mem.addr] <= mem.wdata;
            if (mem.addr < lcd_hex_pkg::disp_bytes)
                shadow[mem.addr[shadow_bits-1:0]] <= mem.wdata;
        end
        else
            mem.rdata <= ram[mem.addr]; // read holds during a write
    end

    // byte 7 is the most significant
    always_comb
    begin
        for (int i = 0; i < lcd_hex_pkg::disp_bytes; i++)
            disp_word[i*8 +: 8] = shadow[i];
    end

endmodule

`default_nettype wire

//--- design/hex_glyph.sv
`default_nettype none

module hex_glyph (
    input  wire  clk,
    input  wire  [lcd_hex_pkg::x_bits-1:0] x,
    input  wire  [lcd_hex_pkg::y_bits-1:0] y,
    input  wire  [lcd_hex_pkg::disp_bytes*8-1:0] disp_word,
    input  wire  frame_start,
    output logic [lcd_hex_pkg::color_bits-1:0] color
);

    logic [lcd_hex_pkg::disp_bytes*8-1:0] word_q;
    logic [2:0] col;
    logic       row;
    logic [3:0] nib_idx;
    logic [3:0] nib;
    logic [1:0] gx;
    logic [2:0] gy;
    logic [3:0] font_row;
    logic       pix;

    // frozen for the whole frame
    always_ff @(posedge clk)
    begin
        if (frame_start)
            word_q <= disp_word;
    end

    always_comb
    begin
        col = 3'(x / lcd_hex_pkg::glyph_w);
        row = 1'(y / lcd_hex_pkg::glyph_h);
        gx  = 2'(x % lcd_hex_pkg::glyph_w);
        gy  = 3'(y % lcd_hex_pkg::glyph_h);

        // 15 - (row*8 + col), top left shows the top nibble
        nib_idx  = ~{row, col};
        nib      = word_q[nib_idx*4 +: 4];
        font_row = lcd_hex_pkg::font[nib][gy];
        pix      = font_row[2'd3 - gx];
    end

    always_ff @(posedge clk)
    begin
        color <= pix ? lcd_hex_pkg::fg_color : lcd_hex_pkg::bg_color;
    end

endmodule

`default_nettype wire

//--- design/pixel_counter.sv
`default_nettype none

module pixel_counter (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  clear,
    input  wire  step,
    input  wire  word16,
    output logic [3:0] bit_idx,
    output logic word_done,
    output logic [lcd_hex_pkg::x_bits-1:0] x,
    output logic [lcd_hex_pkg::y_bits-1:0] y,
    output logic frame_done
);

    logic last_pix; // x,y already wrapped past the final pixel

    assign word_done  = step && (bit_idx == (word16 ? 4'd15 : 4'd7));
    assign frame_done = word_done && word16 && last_pix;

    always_ff @(posedge clk)
    begin
        if (!rst_n || clear)
        begin
            bit_idx  <= 4'd0;
            x        <= '0;
            y        <= '0;
            last_pix <= 1'b0;
        end
        else if (step)
        begin
            bit_idx <= word_done ? 4'd0 : bit_idx + 1'b1;

            // x,y run one pixel ahead so the next glyph is ready at load
            if (word16 && bit_idx == 4'd0)
            begin
                if (x == lcd_hex_pkg::x_bits'(lcd_hex_pkg::lcd_width - 1))
                begin
                    x <= '0;
                    if (y == lcd_hex_pkg::y_bits'(lcd_hex_pkg::lcd_height - 1))
                    begin
                        y        <= '0;
                        last_pix <= 1'b1;
                    end
                    else
                        y <= y + 1'b1;
                end
                else
                    x <= x + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/lcd_fsm.sv
`default_nettype none

module lcd_fsm (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  bit_tick,
    input  wire  word_done,
    input  wire  frame_done,
    input  wire  [lcd_hex_pkg::color_bits-1:0] color,
    output logic clear,
    output logic step,
    output logic word16,
    output logic frame_start,
    output logic load,
    output logic [lcd_hex_pkg::color_bits-1:0] load_word,
    output logic load_dc,
    output logic csn
);

    lcd_hex_pkg::lcd_state_t state, state_next;
    logic [1:0] init_idx;
    logic [1:0] gap_cnt;

    assign clear  = (state == lcd_hex_pkg::idle) || (state == lcd_hex_pkg::gap);
    assign step   = bit_tick & ~clear;
    assign word16 = (state == lcd_hex_pkg::pixels); // width of the word on the wire

    // bytes go out left aligned in the 16-bit load word
    always_comb
    begin
        state_next  = state;
        load        = 1'b0;
        load_word   = {lcd_hex_pkg::ramwr_cmd, 8'h00};
        load_dc     = 1'b0;
        frame_start = 1'b0;
        case (state)
            lcd_hex_pkg::idle:
            begin
                load       = 1'b1;
                load_word  = {lcd_hex_pkg::init_bytes[init_idx], 8'h00};
                state_next = lcd_hex_pkg::init_byte;
            end
            lcd_hex_pkg::init_byte:
                if (word_done)
                begin
                    load = 1'b1;
                    if (init_idx == 2'(lcd_hex_pkg::init_len))
                    begin
                        frame_start = 1'b1;
                        state_next  = lcd_hex_pkg::frame_cmd;
                    end
                    else
                        load_word = {lcd_hex_pkg::init_bytes[init_idx], 8'h00};
                end
            lcd_hex_pkg::frame_cmd:
                if (word_done)
                begin
                    load       = 1'b1;
                    load_word  = color;
                    load_dc    = 1'b1;
                    state_next = lcd_hex_pkg::pixels;
                end
            lcd_hex_pkg::pixels:
                if (frame_done)
                    state_next = lcd_hex_pkg::gap;
                else if (word_done)
                begin
                    load      = 1'b1;
                    load_word = color;
                    load_dc   = 1'b1;
                end
            lcd_hex_pkg::gap:
                if (gap_cnt == 2'(lcd_hex_pkg::gap_cycles - 1))
                begin
                    load        = 1'b1;
                    frame_start = 1'b1;
                    state_next  = lcd_hex_pkg::frame_cmd;
                end
            default: state_next = lcd_hex_pkg::idle;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state    <= lcd_hex_pkg::idle;
            init_idx <= 2'd0;
            gap_cnt  <= 2'd0;
            csn      <= 1'b1;
        end
        else
        begin
            state   <= state_next;
            gap_cnt <= (state == lcd_hex_pkg::gap) ? gap_cnt + 1'b1 : 2'd0;
            if (load && (state == lcd_hex_pkg::idle || state == lcd_hex_pkg::init_byte))
                init_idx <= init_idx + 1'b1;
            if (load)
                csn <= 1'b0;
            else if (frame_done)
                csn <= 1'b1; // released after the last pixel
        end
    end

endmodule

`default_nettype wire

//--- design/spi_shifter.sv
`default_nettype none

module spi_shifter (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  load,
    input  wire  [lcd_hex_pkg::color_bits-1:0] load_word,
    input  wire  word16,
    input  wire  load_dc,
    output logic spi_clk,
    output logic mosi,
    output logic dc,
    output logic bit_tick
);

    logic [lcd_hex_pkg::color_bits-1:0] sr;
    logic [3:0] cnt;  // bits sent of the current word
    logic       busy;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            spi_clk  <= 1'b1; // idle high
            mosi     <= 1'b0;
            dc       <= 1'b0;
            bit_tick <= 1'b0;
            busy     <= 1'b0;
            cnt      <= 4'd0;
        end
        else
        begin
            bit_tick <= 1'b0;
            if (load)
            begin
                spi_clk <= 1'b0;
                mosi    <= load_word[15];
                sr      <= {load_word[14:0], 1'b0};
                dc      <= load_dc;
                cnt     <= 4'd0;
                busy    <= 1'b1;
            end
            else if (busy)
            begin
                if (!spi_clk)
                begin
                    spi_clk  <= 1'b1; // panel samples here
                    bit_tick <= 1'b1;
                end
                else if (cnt == (word16 ? 4'd15 : 4'd7))
                    busy <= 1'b0;
                else
                begin
                    spi_clk <= 1'b0;
                    mosi    <= sr[15];
                    sr      <= {sr[14:0], 1'b0};
                    cnt     <= cnt + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/lcd_hex_top.sv
`default_nettype none

module lcd_hex_top (
    input  wire  clk,
    input  wire  rst_n,
    input  wire  spi_csn,
    input  wire  spi_sclk,
    input  wire  spi_mosi,
    output logic spi_miso,
    output logic lcd_csn,
    output logic lcd_clk,
    output logic lcd_mosi,
    output logic lcd_dc
);

    logic [lcd_hex_pkg::disp_bytes*8-1:0] disp_word;
    logic [lcd_hex_pkg::x_bits-1:0]       x;
    logic [lcd_hex_pkg::y_bits-1:0]       y;
    logic [lcd_hex_pkg::color_bits-1:0]   color;
    logic [lcd_hex_pkg::color_bits-1:0]   load_word;
    logic clear;
    logic step;
    logic word16;
    logic word_done;
    logic frame_done;
    logic frame_start;
    logic load;
    logic load_dc;
    logic bit_tick;

    mem_if mem ();

    spi_rw_slave u_slave (
        .clk   (clk),
        .rst_n (rst_n),
        .csn   (spi_csn),
        .sclk  (spi_sclk),
        .mosi  (spi_mosi),
        .miso  (spi_miso),
        .mem   (mem.slave)
    );

    byte_ram u_ram (
        .clk       (clk),
        .mem       (mem.ram),
        .disp_word (disp_word)
    );

    hex_glyph u_glyph (
        .clk         (clk),
        .x           (x),
        .y           (y),
        .disp_word   (disp_word),
        .frame_start (frame_start),
        .color       (color)
    );

    pixel_counter u_cnt (
        .clk        (clk),
        .rst_n      (rst_n),
        .clear      (clear),
        .step       (step),
        .word16     (word16),
        .bit_idx    (),
        .word_done  (word_done),
        .x          (x),
        .y          (y),
        .frame_done (frame_done)
    );

    lcd_fsm u_fsm (
        .clk         (clk),
        .rst_n       (rst_n),
        .bit_tick    (bit_tick),
        .word_done   (word_done),
        .frame_done  (frame_done),
        .color       (color),
        .clear       (clear),
        .step        (step),
        .word16      (word16),
        .frame_start (frame_start),
        .load        (load),
        .load_word   (load_word),
        .load_dc     (load_dc),
        .csn         (lcd_csn)
    );

    spi_shifter u_shift (
        .clk       (clk),
        .rst_n     (rst_n),
        .load      (load),
        .load_word (load_word),
        .word16    (word16),
        .load_dc   (load_dc),
        .spi_clk   (lcd_clk),
        .mosi      (lcd_mosi),
        .dc        (lcd_dc),
        .bit_tick  (bit_tick)
    );

endmodule

`default_nettype wire

//--- testbench/tb_lcd_hex.sv
`default_nettype none

module tb_lcd_hex;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int     clk_period    = 20;
    localparam int     half_clks     = 10; // 200 ns sclk half period
    localparam int     num_pixels    = lcd_hex_pkg::lcd_width * lcd_hex_pkg::lcd_height;
    localparam int     cells_per_row = lcd_hex_pkg::lcd_width / lcd_hex_pkg::glyph_w;
    localparam longint frame_ns      = ((8 + num_pixels * lcd_hex_pkg::color_bits) * 2
                                       + lcd_hex_pkg::gap_cycles) * clk_period;

    logic clk;
    logic rst_n;
    logic spi_csn;
    logic spi_sclk;
    logic spi_mosi;
    logic spi_miso;
    logic lcd_csn;
    logic lcd_clk;
    logic lcd_mosi;
    logic lcd_dc;

    // transactions from the pattern file
    logic [7:0] kind_q  [$];
    logic [7:0] op_q    [$];
    logic [7:0] addr_q  [$];
    int         count_q [$];
    logic [7:0] data_q  [$]; // data or expected bytes of all lines in order
    int         pattern_count;
    bit         patterns_loaded;

    logic [7:0]  model [lcd_hex_pkg::ram_depth]; // bytes written so far
    logic [7:0]  cmd_bytes [lcd_hex_pkg::init_len + 1];
    logic [15:0] pix_seen [num_pixels];
    int          cmd_count;
    int          frames_started;
    int          frames_done;
    int          check_frame;
    int          csn_gaps; // completed chip select gaps

    lcd_hex_top i_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .spi_csn  (spi_csn),
        .spi_sclk (spi_sclk),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso),
        .lcd_csn  (lcd_csn),
        .lcd_clk  (lcd_clk),
        .lcd_mosi (lcd_mosi),
        .lcd_dc   (lcd_dc)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_with_failure(input string reason);
        if (reason != "")
            $display("%s", reason);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("Error at %t: %s expected %0h, got %0h", $realtime, name, expected, actual);
            stop_with_failure("");
        end
    endtask

    // n rising edges, then step off the edge before driving
    task automatic wait_clocks(input int n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // mode 0, msb first, miso sampled just before sclk rises
    task automatic shift_byte(input logic [7:0] tx, input int nbits, output logic [7:0] rx);
        int i;
        rx = 8'h00;
        for (i = 7; i > 7 - nbits; i--)
        begin
            spi_sclk = 1'b0;
            spi_mosi = tx[i];
            wait_clocks(half_clks);
            rx       = {rx[6:0], spi_miso};
            spi_sclk = 1'b1;
            wait_clocks(half_clks);
        end
        spi_sclk = 1'b0;
    endtask

    task automatic load_patterns();
        int               fd;
        int               code;
        int               cnt;
        int               nbytes;
        int               k;
        logic [7:0]       kind;
        logic [7:0]       op;
        logic [7:0]       addr;
        logic [7:0]       b;
        logic [8*200-1:0] line;
        fd = $fopen("testbench/spi_patterns.txt", "r");
        if (fd == 0)
            stop_with_failure("Cannot open the pattern file testbench/spi_patterns.txt");
        else
        begin
            while ($fscanf(fd, " %c", kind) == 1)
            begin
                if (kind == "#")
                    code = $fgets(line, fd); // comment line
                else if (kind == "w" || kind == "r" || kind == "u" || kind == "a")
                begin
                    code = $fscanf(fd, "%h %h %d", op, addr, cnt);
                    if (code != 3)
                        stop_with_failure("Pattern file has a line with missing fields");
                    nbytes = (kind == "a") ? 1 : cnt;
                    for (k = 0; k < nbytes; k++)
                    begin
                        code = $fscanf(fd, "%h", b);
                        if (code != 1)
                            stop_with_failure("Pattern file has a line with too few bytes");
                        data_q.push_back(b);
                    end
                    kind_q.push_back(kind);
                    op_q.push_back(op);
                    addr_q.push_back(addr);
                    count_q.push_back(cnt);
                end
                else
                    stop_with_failure("Pattern file has a line of unknown kind");
            end
            $fclose(fd);
        end
        pattern_count = kind_q.size();
    endtask

    task automatic run_pattern(input int n, inout int di);
        logic [7:0] kind;
        logic [7:0] addr;
        logic [7:0] rx;
        int         k;
        kind = kind_q[n];
        addr = addr_q[n];
        wait_clocks(1);
        spi_csn = 1'b0;
        wait_clocks(half_clks);
        shift_byte(op_q[n], 8, rx);
        shift_byte(addr, 8, rx);
        if (kind == "a")
        begin
            shift_byte(data_q[di], count_q[n], rx); // csn rises after a partial byte
            di++;
        end
        else
        begin
            for (k = 0; k < count_q[n]; k++)
            begin
                if (kind == "r")
                begin
                    shift_byte(8'h00, 8, rx);
                    check_value($sformatf("spi_miso at addr %02h", addr), data_q[di], rx);
                end
                else
                begin
                    shift_byte(data_q[di], 8, rx);
                    if (kind == "w")
                        model[addr] = data_q[di];
                end
                addr = addr + 1'b1; // wraps at 255
                di++;
            end
        end
        wait_clocks(half_clks);
        spi_csn = 1'b1;
        wait_clocks(2 * half_clks);
    endtask

    function automatic logic [15:0] expected_pixel(input int px, input int py);
        logic [63:0] word;
        logic [3:0]  nib;
        logic [3:0]  font_row;
        int          nib_idx;
        int          i;
        for (i = 0; i < lcd_hex_pkg::disp_bytes; i++)
            word[i*8 +: 8] = model[i]; // byte 7 on top
        // top left cell holds the most significant nibble
        nib_idx  = 15 - ((py / lcd_hex_pkg::glyph_h) * cells_per_row
                   + px / lcd_hex_pkg::glyph_w);
        nib      = word[nib_idx*4 +: 4];
        font_row = lcd_hex_pkg::font[nib][py % lcd_hex_pkg::glyph_h];
        if (font_row[3 - px % lcd_hex_pkg::glyph_w])
            return lcd_hex_pkg::fg_color;
        else
            return lcd_hex_pkg::bg_color;
    endfunction

    initial
    begin : main
        int di;
        int n;
        int i;
        clk      = 1'b0;
        rst_n    = 1'b0;
        spi_csn  = 1'b1;
        spi_sclk = 1'b0;
        spi_mosi = 1'b0;
        di             = 0;
        cmd_count      = 0;
        frames_started = 0;
        frames_done    = 0;
        check_frame    = -1;
        csn_gaps       = 0;
        $timeformat(-9, 1, " ns", 10);
        load_patterns();
        if (pattern_count == 0)
            stop_with_failure("Pattern file holds no transactions");
        patterns_loaded = 1'b1;

        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // init bytes, then the first memory write command
        wait (cmd_count == lcd_hex_pkg::init_len + 1);
        for (i = 0; i < lcd_hex_pkg::init_len; i++)
            check_value($sformatf("lcd_mosi init byte %0d", i),
                        lcd_hex_pkg::init_bytes[i], cmd_bytes[i]);
        check_value("lcd_mosi frame command", lcd_hex_pkg::ramwr_cmd,
                    cmd_bytes[lcd_hex_pkg::init_len]);

        for (n = 0; n < pattern_count; n++)
            run_pattern(n, di);

        for (i = 0; i < lcd_hex_pkg::disp_bytes; i++)
            if ($isunknown(model[i]))
                stop_with_failure($sformatf("Pattern file never writes display byte %0d", i));

        // next frame to start sees the final display word
        check_frame = frames_started;
        wait (frames_done > check_frame);
        for (i = 0; i < num_pixels; i++)
            check_value($sformatf("lcd_mosi pixel x=%0d y=%0d", i % lcd_hex_pkg::lcd_width,
                                  i / lcd_hex_pkg::lcd_width),
                        expected_pixel(i % lcd_hex_pkg::lcd_width, i / lcd_hex_pkg::lcd_width),
                        pix_seen[i]);

        $display("No errors");
        $finish;
    end

    // decodes the panel stream, one bit per rising lcd_clk
    initial
    begin : lcd_monitor
        int          bit_pos;
        int          cmd_bits;
        int          pbit;
        logic [15:0] sh;
        bit_pos = 0;
        sh      = 16'h0000;
        wait (rst_n === 1'b1);
        forever
        begin
            @(posedge lcd_clk);
            if (lcd_csn === 1'b0)
            begin
                if (bit_pos == 0)
                begin
                    frames_started++;
                    check_value("lcd_csn gaps before frame", frames_done, csn_gaps);
                end
                sh       = {sh[14:0], lcd_mosi};
                cmd_bits = (frames_done == 0) ? (lcd_hex_pkg::init_len + 1) * 8 : 8;
                if (bit_pos < cmd_bits)
                begin
                    check_value("lcd_dc", 0, lcd_dc);
                    if (bit_pos % 8 == 7)
                    begin
                        if (frames_done == 0)
                        begin
                            cmd_bytes[bit_pos / 8] = sh[7:0];
                            cmd_count++;
                        end
                        else
                            check_value("lcd_mosi frame command", lcd_hex_pkg::ramwr_cmd,
                                        sh[7:0]);
                    end
                    bit_pos++;
                end
                else
                begin
                    check_value("lcd_dc", 1, lcd_dc); // pixel data
                    pbit = bit_pos - cmd_bits;
                    bit_pos++;
                    if (pbit % 16 == 15)
                    begin
                        pix_seen[pbit / 16] = sh;
                        if (pbit / 16 == num_pixels - 1)
                        begin
                            bit_pos = 0;
                            frames_done++;
                        end
                    end
                end
            end
        end
    end

    // chip select rises after the last pixel and stays high for the gap
    initial
    begin : csn_monitor
        int high_clks;
        wait (rst_n === 1'b1);
        forever
        begin
            @(posedge lcd_csn);
            check_value("lcd_csn rise frame count", csn_gaps + 1, frames_done);
            high_clks = 0;
            @(negedge clk);
            while (lcd_csn === 1'b1)
            begin
                high_clks++;
                @(negedge clk);
            end
            check_value("lcd_csn high cycles", lcd_hex_pkg::gap_cycles, high_clks);
            csn_gaps++;
        end
    end

    initial
    begin : watchdog
        longint limit_ns;
        wait (patterns_loaded);
        limit_ns = longint'(pattern_count) * 40_000 + 3 * frame_ns;
        #(limit_ns);
        stop_with_failure("Timeout: SPI traffic or the checked LCD frame did not finish in time");
    end

endmodule

`default_nettype wire

//--- testbench/spi_patterns.txt
# kind opcode addr count bytes; hex fields, count in decimal
# kind w write, r read expecting bytes, u ignored opcode, a csn raised after count bits
w 02 00 8 01 23 45 67 89 ab cd ef
r 03 00 8 01 23 45 67 89 ab cd ef
w 02 fe 4 a1 b2 c3 d4
r 03 fe 4 a1 b2 c3 d4
r 03 02 2 45 67
w 02 20 3 5a 6b 7c
u 5a 20 3 00 11 22
u 07 21 1 ff
r 03 20 3 5a 6b 7c
w 02 30 2 3c 4d
a 02 30 4 ff
a 02 31 7 00
r 03 30 2 3c 4d
w 02 80 1 e7
r 03 80 1 e7
w 02 00 2 fe dc
w 02 05 3 10 32 54
r 03 00 8 fe dc 45 67 89 10 32 54

//--- project.f
design/lcd_hex_pkg.sv
design/mem_if.sv
design/spi_rw_slave.sv
design/byte_ram.sv
design/hex_glyph.sv
design/pixel_counter.sv
design/lcd_fsm.sv
design/spi_shifter.sv
design/lcd_hex_top.sv
testbench/tb_lcd_hex.sv

//--- Bender.yml
package:
  name: lcd_hex

sources:
  - design/lcd_hex_pkg.sv
  - design/mem_if.sv
  - design/spi_rw_slave.sv
  - design/byte_ram.sv
  - design/hex_glyph.sv
  - design/pixel_counter.sv
  - design/lcd_fsm.sv
  - design/spi_shifter.sv
  - design/lcd_hex_top.sv
  - target: simulation
    files:
      - testbench/tb_lcd_hex.sv
